//--- files.f
isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decode_unit.sv
rename_dispatch.sv
exec_unit.sv
reorder_buffer.sv
helios_core.sv
tb_helios_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the helios_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 -Wno-fatal \
  --top-module tb_helios_core -f files.f -o sim_helios
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_helios > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
  exit 0
fi
exit 1

//--- tb_helios_core.sv
module tb_helios_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          IMEM_WORDS = 256;
  localparam int          RAND_LEN   = 160;
  localparam logic [31:0] NOP        = 32'h0000_0013;
  localparam logic [6:0]  OP_REG     = 7'b0110011;
  localparam logic [6:0]  OP_IMM     = 7'b0010011;
  localparam logic [6:0]  OP_LUI     = 7'b0110111;

  logic              clk;
  logic              arst_n;
  logic [31:0]       idata;
  logic [31:0]       pc;
  core_pkg::retire_t retire;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] prog_len;
  logic [31:0] model_rf [32];
  logic [31:0] model_pc;
  logic        checking;
  logic [31:0] rng;
  int          retired;
  int          value_errs;
  int          other_errs;
  string       test_name;

  helios_core dut0 (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .idata_i  (idata),
    .pc_o     (pc),
    .retire_o (retire)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Few registers so that dependencies are frequent
  function automatic logic [4:0] pick_reg(input logic [2:0] b);
    return (b > 3'd5) ? {2'b00, b - 3'd4} : {2'b00, b};
  endfunction

  function automatic logic [31:0] random_insn(input logic [31:0] r);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] insn;
    rd  = pick_reg(r[6:4]);
    rs1 = pick_reg(r[13:11]);
    rs2 = pick_reg(r[16:14]);
    case (r[10:7])
      4'd0, 4'd1:   insn = r_type(7'b0000000, rs2, rs1, 3'b000, rd);
      4'd2:         insn = r_type(7'b0100000, rs2, rs1, 3'b000, rd);
      4'd3:         insn = r_type(7'b0000000, rs2, rs1, 3'b111, rd);
      4'd4:         insn = r_type(7'b0000000, rs2, rs1, 3'b110, rd);
      4'd5:         insn = r_type(7'b0000000, rs2, rs1, 3'b100, rd);
      4'd6:         insn = r_type(7'b0000000, rs2, rs1, 3'b010, rd);
      4'd7:         insn = i_type(3'b000, rd, rs1, r[31:20]);
      4'd8:         insn = i_type(3'b111, rd, rs1, r[31:20]);
      4'd9:         insn = i_type(3'b110, rd, rs1, r[31:20]);
      4'd10:        insn = i_type(3'b100, rd, rs1, r[31:20]);
      4'd11:        insn = u_type(rd, r[31:12]);
      4'd12, 4'd13: insn = r_type(7'b0000001, rs2, rs1, 3'b000, rd);
      // SLL is not supported
      4'd14:        insn = r_type(7'b0000000, rs2, rs1, 3'b001, rd);
      default:      insn = {r[31:7], 7'b0000000};
    endcase
    return insn;
  endfunction

  // Past the end of the program the memory answers with a nop
  function automatic logic [31:0] prog_word(input logic [31:0] addr);
    if ({2'b00, addr[31:2]} < prog_len) begin
      return imem[addr[9:2]];
    end
    return NOP;
  endfunction

  always_comb idata = prog_word(pc);

  // Reference semantics of the supported subset
  function automatic void predict(input logic [31:0] insn, output logic wr,
                                  output logic ill, output logic [31:0] val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    opc = insn[6:0];
    f3  = insn[14:12];
    f7  = insn[31:25];
    a   = model_rf[insn[19:15]];
    b   = model_rf[insn[24:20]];
    imm = {{20{insn[31]}}, insn[31:20]};
    ill = 1'b0;
    val = '0;
    if (opc == OP_REG && f7 == 7'b0000000) begin
      case (f3)
        3'b000:  val = a + b;
        3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  val = a ^ b;
        3'b110:  val = a | b;
        3'b111:  val = a & b;
        default: ill = 1'b1;
      endcase
    end else if (opc == OP_REG && f7 == 7'b0100000 && f3 == 3'b000) begin
      val = a - b;
    end else if (opc == OP_REG && f7 == 7'b0000001 && f3 == 3'b000) begin
      val = a * b;
    end else if (opc == OP_IMM) begin
      case (f3)
        3'b000:  val = a + imm;
        3'b100:  val = a ^ imm;
        3'b110:  val = a | imm;
        3'b111:  val = a & imm;
        default: ill = 1'b1;
      endcase
    end else if (opc == OP_LUI) begin
      val = {insn[31:12], 12'b0};
    end else begin
      ill = 1'b1;
    end
    wr = !ill && (insn[11:7] != 5'd0);
  endfunction

  task automatic append_insn(input logic [31:0] insn);
    imem[prog_len[7:0]] = insn;
    prog_len = prog_len + 32'd1;
  endtask

  task automatic load_directed();
    prog_len = '0;
    append_insn(i_type(3'b000, 5'd1, 5'd0, 12'd5));
    append_insn(i_type(3'b000, 5'd2, 5'd0, 12'hffd));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
    append_insn(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd7));
    // Signed compare both ways
    append_insn(r_type(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd8));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd9));
    append_insn(u_type(5'd10, 20'habcde));
    append_insn(i_type(3'b110, 5'd11, 5'd10, 12'h123));
    append_insn(i_type(3'b111, 5'd12, 5'd11, 12'hff0));
    append_insn(i_type(3'b100, 5'd13, 5'd12, 12'h7ff));
    // MUL chain that stalls dispatch
    append_insn(r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd14));
    append_insn(r_type(7'b0000001, 5'd14, 5'd14, 3'b000, 5'd15));
    append_insn(r_type(7'b0000000, 5'd1, 5'd15, 3'b000, 5'd16));
    // Independent ALU work behind a MUL
    append_insn(r_type(7'b0000001, 5'd4, 5'd3, 3'b000, 5'd17));
    append_insn(i_type(3'b000, 5'd18, 5'd0, 12'd1));
    append_insn(i_type(3'b000, 5'd19, 5'd18, 12'd1));
    append_insn(i_type(3'b000, 5'd18, 5'd19, 12'd1));
    append_insn(r_type(7'b0000000, 5'd17, 5'd18, 3'b000, 5'd19));
    // Illegal SLL and SLTI must leave x20 alone
    append_insn(i_type(3'b000, 5'd20, 5'd0, 12'd77));
    append_insn(r_type(7'b0000000, 5'd2, 5'd1, 3'b001, 5'd20));
    append_insn(i_type(3'b010, 5'd20, 5'd1, 12'd100));
    append_insn(32'h0000_0000);
    append_insn(r_type(7'b0000000, 5'd0, 5'd20, 3'b000, 5'd21));
    // x0 as destination and source
    append_insn(i_type(3'b000, 5'd0, 5'd1, 12'd9));
    append_insn(r_type(7'b0000001, 5'd1, 5'd1, 3'b000, 5'd0));
    append_insn(r_type(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd22));
    append_insn(i_type(3'b000, 5'd23, 5'd0, 12'hfff));
    append_insn(r_type(7'b0000000, 5'd0, 5'd23, 3'b110, 5'd24));
    append_insn(r_type(7'b0000001, 5'd1, 5'd1, 3'b000, 5'd25));
    append_insn(r_type(7'b0000001, 5'd2, 5'd2, 3'b000, 5'd26));
    append_insn(r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd27));
    append_insn(r_type(7'b0000000, 5'd26, 5'd25, 3'b000, 5'd28));
  endtask

  task automatic load_random();
    prog_len = '0;
    for (int i = 0; i < RAND_LEN; i++) begin
      rng = xorshift32(rng);
      append_insn(random_insn(rng));
    end
  endtask

  task automatic restart_model();
    for (int r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end
    model_pc = core_pkg::RESET_PC;
    retired  = 0;
  endtask

  task automatic hold_reset();
    @(posedge clk);
    checking = 1'b0;
    @(negedge clk);
    arst_n = 1'b0;
  endtask

  task automatic release_reset();
    repeat (3) begin
      @(negedge clk);
      assert (pc == core_pkg::RESET_PC && !retire.valid) else begin
        $display("PC or retire valid is wrong while reset is held");
        other_errs++;
      end
    end
    arst_n   = 1'b1;
    checking = 1'b1;
  endtask

  task automatic check_retire();
    logic [31:0] insn;
    logic        exp_wr;
    logic        exp_ill;
    logic [31:0] exp_val;
    insn = prog_word(model_pc);
    predict(insn, exp_wr, exp_ill, exp_val);
    assert (retire.pc == model_pc) else begin
      $display("ERR %s pc: expected %h actual %h", test_name, model_pc, retire.pc);
      value_errs++;
    end
    assert (retire.illegal == exp_ill) else begin
      $display("ERR %s illegal at pc %h: expected %b actual %b",
               test_name, model_pc, exp_ill, retire.illegal);
      value_errs++;
    end
    assert (retire.wr_reg == exp_wr) else begin
      $display("ERR %s wr_reg at pc %h: expected %b actual %b",
               test_name, model_pc, exp_wr, retire.wr_reg);
      value_errs++;
    end
    assert (retire.rd == insn[11:7]) else begin
      $display("ERR %s rd at pc %h: expected %0d actual %0d",
               test_name, model_pc, insn[11:7], retire.rd);
      value_errs++;
    end
    if (exp_wr) begin
      assert (retire.data == exp_val) else begin
        $display("ERR %s data at pc %h: expected %h actual %h",
                 test_name, model_pc, exp_val, retire.data);
        value_errs++;
      end
      model_rf[insn[11:7]] = exp_val;
    end
    model_pc = model_pc + 32'd4;
    retired++;
  endtask

  always @(negedge clk) begin
    if (checking && arst_n && retire.valid) begin
      check_retire();
    end
  end

  task automatic wait_retired(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (retired < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (retired < target) begin
      $display("Timeout in %s: %0d of %0d instructions retired after %0d cycles",
               test_name, retired, target, cycles);
      other_errs++;
    end
  endtask

  assert property (@(posedge clk) !arst_n |-> (pc == core_pkg::RESET_PC && !retire.valid))
    else begin
      $display("Core is not in its reset state while reset is asserted");
      other_errs = other_errs + 1;
    end

  assert property (@(posedge clk) $rose(arst_n) |-> (pc == core_pkg::RESET_PC && !retire.valid))
    else begin
      $display("Core left its reset state before the first edge after reset");
      other_errs = other_errs + 1;
    end

  assert property (@(posedge clk) disable iff (!arst_n)
                   retire.valid && retire.illegal |-> !retire.wr_reg)
    else begin
      $display("Illegal instruction retired with a register write");
      other_errs = other_errs + 1;
    end

  assert property (@(posedge clk) disable iff (!arst_n)
                   retire.valid && retire.rd == 5'd0 |-> !retire.wr_reg)
    else begin
      $display("Write to x0 retired with a register write");
      other_errs = other_errs + 1;
    end

  initial begin
    arst_n     = 1'b0;
    checking   = 1'b0;
    prog_len   = '0;
    rng        = 32'hf450_6a98;
    value_errs = 0;
    other_errs = 0;
    test_name  = "directed";
    restart_model();
    hold_reset();
    load_directed();
    restart_model();
    release_reset();
    wait_retired(int'(prog_len) + 4, 40 * (int'(prog_len) + 4));

    test_name = "random";
    hold_reset();
    load_random();
    restart_model();
    release_reset();
    wait_retired(int'(prog_len) + 4, 40 * (int'(prog_len) + 4));

    $display("Errors: value %0d, other %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- helios_core.sv
module helios_core (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [core_pkg::XLEN-1:0] idata_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output core_pkg::retire_t         retire_o
);

  logic                    stall_dp;
  core_pkg::fetch_pkt_t    fetch_pkt;
  core_pkg::dec_pkt_t      dec_pkt;
  core_pkg::issue_pkt_t    issue_pkt;
  core_pkg::dispatch_pkt_t dispatch_pkt;
  core_pkg::wb_pkt_t       alu_wb;
  core_pkg::wb_pkt_t       mul_wb;
  core_pkg::commit_pkt_t   commit_pkt;

  // IF stage
  fetch_unit u_fetch_unit (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_dp),
    .insn_i   (idata_i),
    .pc_o     (pc_o),
    .fetch_o  (fetch_pkt)
  );

  // ID stage
  decode_unit u_decode_unit (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_dp),
    .fetch_i  (fetch_pkt),
    .dec_o    (dec_pkt)
  );

  // DP stage
  rename_dispatch u_rename_dispatch (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .dec_i      (dec_pkt),
    .alu_wb_i   (alu_wb),
    .mul_wb_i   (mul_wb),
    .commit_i   (commit_pkt),
    .stall_o    (stall_dp),
    .issue_o    (issue_pkt),
    .dispatch_o (dispatch_pkt),
    .retire_o   (retire_o)
  );

  // EX stage
  exec_unit u_exec_unit (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .issue_i  (issue_pkt),
    .alu_wb_o (alu_wb),
    .mul_wb_o (mul_wb)
  );

  // COM stage
  reorder_buffer u_reorder_buffer (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .dispatch_i (dispatch_pkt),
    .alu_wb_i   (alu_wb),
    .mul_wb_i   (mul_wb),
    .commit_o   (commit_pkt)
  );

endmodule

//--- reorder_buffer.sv
module reorder_buffer (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  core_pkg::dispatch_pkt_t dispatch_i,
  input  core_pkg::wb_pkt_t       alu_wb_i,
  input  core_pkg::wb_pkt_t       mul_wb_i,
  output core_pkg::commit_pkt_t   commit_o
);

  logic [core_pkg::XLEN-1:0]        ent_pc [core_pkg::ROB_ENTRIES];
  logic [core_pkg::REG_SEL-1:0]     ent_rd [core_pkg::ROB_ENTRIES];
  logic [core_pkg::ROB_ENTRIES-1:0] ent_wr_reg;
  logic [core_pkg::ROB_ENTRIES-1:0] ent_illegal;
  logic [core_pkg::ROB_ENTRIES-1:0] done;
  logic [core_pkg::ROB_SEL-1:0]     head;

  always_ff @(posedge clk_i) begin
    if (dispatch_i.valid) begin
      ent_pc[dispatch_i.tag]      <= dispatch_i.pc;
      ent_rd[dispatch_i.tag]      <= dispatch_i.rd;
      ent_wr_reg[dispatch_i.tag]  <= dispatch_i.wr_reg;
      ent_illegal[dispatch_i.tag] <= dispatch_i.illegal;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done <= '0;
      head <= '0;
    end else begin
      if (commit_o.valid) begin
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      if (alu_wb_i.valid) begin
        done[alu_wb_i.tag] <= 1'b1;
      end
      if (mul_wb_i.valid) begin
        done[mul_wb_i.tag] <= 1'b1;
      end
    end
  end

  // Head retires as soon as it is done
  always_comb begin
    commit_o.valid   = done[head];
    commit_o.tag     = head;
    commit_o.pc      = ent_pc[head];
    commit_o.rd      = ent_rd[head];
    commit_o.wr_reg  = ent_wr_reg[head];
    commit_o.illegal = ent_illegal[head];
  end

endmodule

//--- exec_unit.sv
module exec_unit (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  core_pkg::issue_pkt_t issue_i,
  output core_pkg::wb_pkt_t    alu_wb_o,
  output core_pkg::wb_pkt_t    mul_wb_o
);

  logic [core_pkg::XLEN-1:0] alu_res;
  core_pkg::wb_pkt_t         mul_pipe [core_pkg::MUL_LATENCY];

  always_comb begin
    case (issue_i.alu_op)
      isa_pkg::ALU_ADD: alu_res = issue_i.op_a + issue_i.op_b;
      isa_pkg::ALU_SUB: alu_res = issue_i.op_a - issue_i.op_b;
      isa_pkg::ALU_AND: alu_res = issue_i.op_a & issue_i.op_b;
      isa_pkg::ALU_OR:  alu_res = issue_i.op_a | issue_i.op_b;
      isa_pkg::ALU_XOR: alu_res = issue_i.op_a ^ issue_i.op_b;
      isa_pkg::ALU_SLT: begin
        alu_res = ($signed(issue_i.op_a) < $signed(issue_i.op_b)) ?
                  (core_pkg::XLEN)'(1) : '0;
      end
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      alu_wb_o <= '0;
    end else begin
      alu_wb_o.valid <= issue_i.valid && !issue_i.is_mul;
      alu_wb_o.tag   <= issue_i.tag;
      alu_wb_o.data  <= alu_res;
    end
  end

  // Multiplier keeps the low half of the product
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < core_pkg::MUL_LATENCY; s++) begin
        mul_pipe[s] <= '0;
      end
    end else begin
      mul_pipe[0].valid <= issue_i.valid && issue_i.is_mul;
      mul_pipe[0].tag   <= issue_i.tag;
      mul_pipe[0].data  <= issue_i.op_a * issue_i.op_b;
      for (int s = 1; s < core_pkg::MUL_LATENCY; s++) begin
        mul_pipe[s] <= mul_pipe[s-1];
      end
    end
  end

  assign mul_wb_o = mul_pipe[core_pkg::MUL_LATENCY-1];

endmodule

//--- rename_dispatch.sv
module rename_dispatch (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  core_pkg::dec_pkt_t      dec_i,
  input  core_pkg::wb_pkt_t       alu_wb_i,
  input  core_pkg::wb_pkt_t       mul_wb_i,
  input  core_pkg::commit_pkt_t   commit_i,
  output logic                    stall_o,
  output core_pkg::issue_pkt_t    issue_o,
  output core_pkg::dispatch_pkt_t dispatch_o,
  output core_pkg::retire_t       retire_o
);

  logic [core_pkg::XLEN-1:0]        arf      [core_pkg::NUM_AREGS];
  logic [core_pkg::NUM_AREGS-1:0]   busy;
  logic [core_pkg::ROB_SEL-1:0]     rtag     [core_pkg::NUM_AREGS];
  logic [core_pkg::XLEN-1:0]        rrf_data [core_pkg::ROB_ENTRIES];
  logic [core_pkg::ROB_ENTRIES-1:0] rrf_valid;
  logic [core_pkg::ROB_SEL-1:0]     alloc_ptr;
  logic [core_pkg::ROB_SEL:0]       free_cnt;

  logic [core_pkg::REG_SEL-1:0] src_reg [2];
  logic                         src_use [2];
  logic                         src_rdy [2];
  logic [core_pkg::XLEN-1:0]    src_val [2];
  logic                         srcs_ok;
  logic                         tag_ok;
  logic                         do_issue;

  assign src_reg[0] = dec_i.rs1;
  assign src_reg[1] = dec_i.rs2;
  assign src_use[0] = dec_i.uses_rs1;
  assign src_use[1] = dec_i.uses_rs2;

  // Operands come from the ARF, the RRF or a writeback port this cycle
  always_comb begin
    logic [core_pkg::ROB_SEL-1:0] t;
    for (int i = 0; i < 2; i++) begin
      t          = rtag[src_reg[i]];
      src_rdy[i] = 1'b1;
      src_val[i] = arf[src_reg[i]];
      if (busy[src_reg[i]]) begin
        if (rrf_valid[t]) begin
          src_val[i] = rrf_data[t];
        end else if (alu_wb_i.valid && alu_wb_i.tag == t) begin
          src_val[i] = alu_wb_i.data;
        end else if (mul_wb_i.valid && mul_wb_i.tag == t) begin
          src_val[i] = mul_wb_i.data;
        end else begin
          src_rdy[i] = 1'b0;
        end
      end
    end
  end

  assign srcs_ok  = (!src_use[0] || src_rdy[0]) && (!src_use[1] || src_rdy[1]);
  // A commit this cycle frees the head tag for reuse
  assign tag_ok   = (free_cnt != '0) || commit_i.valid;
  assign stall_o  = dec_i.valid && !(srcs_ok && tag_ok);
  assign do_issue = dec_i.valid && !stall_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_o    <= '0;
      dispatch_o <= '0;
    end else begin
      issue_o.valid      <= do_issue;
      issue_o.is_mul     <= dec_i.is_mul;
      issue_o.alu_op     <= dec_i.alu_op;
      issue_o.op_a       <= src_val[0];
      issue_o.op_b       <= dec_i.src_b_imm ? dec_i.imm : src_val[1];
      issue_o.tag        <= alloc_ptr;
      dispatch_o.valid   <= do_issue;
      dispatch_o.tag     <= alloc_ptr;
      dispatch_o.pc      <= dec_i.pc;
      dispatch_o.rd      <= dec_i.rd;
      dispatch_o.wr_reg  <= dec_i.wr_reg;
      dispatch_o.illegal <= dec_i.illegal;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < core_pkg::NUM_AREGS; r++) begin
        arf[r] <= '0;
      end
      busy      <= '0;
      rrf_valid <= '0;
      alloc_ptr <= '0;
      free_cnt  <= (core_pkg::ROB_SEL + 1)'(core_pkg::ROB_ENTRIES);
    end else begin
      if (alu_wb_i.valid) begin
        rrf_valid[alu_wb_i.tag] <= 1'b1;
      end
      if (mul_wb_i.valid) begin
        rrf_valid[mul_wb_i.tag] <= 1'b1;
      end
      if (commit_i.valid && commit_i.wr_reg) begin
        arf[commit_i.rd] <= rrf_data[commit_i.tag];
        if (rtag[commit_i.rd] == commit_i.tag) begin
          busy[commit_i.rd] <= 1'b0;
        end
      end
      // Comes after commit so a same-cycle rename keeps rd busy
      if (do_issue) begin
        alloc_ptr            <= alloc_ptr + 1'b1;
        rrf_valid[alloc_ptr] <= 1'b0;
        if (dec_i.wr_reg) begin
          busy[dec_i.rd] <= 1'b1;
        end
      end
      free_cnt <= free_cnt - (core_pkg::ROB_SEL + 1)'(do_issue)
                           + (core_pkg::ROB_SEL + 1)'(commit_i.valid);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_issue && dec_i.wr_reg) begin
      rtag[dec_i.rd] <= alloc_ptr;
    end
    if (alu_wb_i.valid) begin
      rrf_data[alu_wb_i.tag] <= alu_wb_i.data;
    end
    if (mul_wb_i.valid) begin
      rrf_data[mul_wb_i.tag] <= mul_wb_i.data;
    end
  end

  always_comb begin
    retire_o.valid   = commit_i.valid;
    retire_o.pc      = commit_i.pc;
    retire_o.rd      = commit_i.rd;
    retire_o.wr_reg  = commit_i.wr_reg;
    retire_o.data    = rrf_data[commit_i.tag];
    retire_o.illegal = commit_i.illegal;
  end

endmodule

//--- decode_unit.sv
module decode_unit (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 stall_i,
  input  core_pkg::fetch_pkt_t fetch_i,
  output core_pkg::dec_pkt_t   dec_o
);

  logic [6:0]                   opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [core_pkg::REG_SEL-1:0] rd;
  logic [core_pkg::REG_SEL-1:0] rs1;
  logic [core_pkg::REG_SEL-1:0] rs2;
  logic                         legal;
  core_pkg::dec_pkt_t           dec_d;

  assign opcode = fetch_i.insn[6:0];
  assign rd     = fetch_i.insn[11:7];
  assign funct3 = fetch_i.insn[14:12];
  assign rs1    = fetch_i.insn[19:15];
  assign rs2    = fetch_i.insn[24:20];
  assign funct7 = fetch_i.insn[31:25];

  always_comb begin
    dec_d        = '0;
    dec_d.valid  = fetch_i.valid;
    dec_d.pc     = fetch_i.pc;
    dec_d.rd     = rd;
    dec_d.alu_op = isa_pkg::ALU_ADD;
    legal        = 1'b1;
    case (opcode)
      isa_pkg::OPC_OP: begin
        dec_d.uses_rs1 = 1'b1;
        dec_d.uses_rs2 = 1'b1;
        dec_d.wr_reg   = 1'b1;
        if (funct7 == isa_pkg::F7_BASE) begin
          case (funct3)
            isa_pkg::F3_ADD_SUB: dec_d.alu_op = isa_pkg::ALU_ADD;
            isa_pkg::F3_SLT:     dec_d.alu_op = isa_pkg::ALU_SLT;
            isa_pkg::F3_XOR:     dec_d.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_OR:      dec_d.alu_op = isa_pkg::ALU_OR;
            isa_pkg::F3_AND:     dec_d.alu_op = isa_pkg::ALU_AND;
            default:             legal = 1'b0;
          endcase
        end else if (funct7 == isa_pkg::F7_SUB && funct3 == isa_pkg::F3_ADD_SUB) begin
          dec_d.alu_op = isa_pkg::ALU_SUB;
        end else if (funct7 == isa_pkg::F7_MULDIV && funct3 == isa_pkg::F3_ADD_SUB) begin
          // MUL shares funct3 000 with ADD
          dec_d.alu_op = isa_pkg::ALU_MUL;
          dec_d.is_mul = 1'b1;
        end else begin
          legal = 1'b0;
        end
      end
      isa_pkg::OPC_OP_IMM: begin
        dec_d.uses_rs1  = 1'b1;
        dec_d.wr_reg    = 1'b1;
        dec_d.src_b_imm = 1'b1;
        dec_d.imm       = {{20{fetch_i.insn[31]}}, fetch_i.insn[31:20]};
        case (funct3)
          isa_pkg::F3_ADD_SUB: dec_d.alu_op = isa_pkg::ALU_ADD;
          isa_pkg::F3_XOR:     dec_d.alu_op = isa_pkg::ALU_XOR;
          isa_pkg::F3_OR:      dec_d.alu_op = isa_pkg::ALU_OR;
          isa_pkg::F3_AND:     dec_d.alu_op = isa_pkg::ALU_AND;
          default:             legal = 1'b0;
        endcase
      end
      isa_pkg::OPC_LUI: begin
        // x0 + imm through the adder
        dec_d.wr_reg    = 1'b1;
        dec_d.src_b_imm = 1'b1;
        dec_d.imm       = {fetch_i.insn[31:12], 12'b0};
      end
      default: legal = 1'b0;
    endcase

    // Illegal goes down the pipe as a nop
    if (!legal) begin
      dec_d.uses_rs1  = 1'b0;
      dec_d.uses_rs2  = 1'b0;
      dec_d.wr_reg    = 1'b0;
      dec_d.src_b_imm = 1'b0;
      dec_d.imm       = '0;
      dec_d.is_mul    = 1'b0;
      dec_d.alu_op    = isa_pkg::ALU_ADD;
      dec_d.illegal   = 1'b1;
    end
    if (rd == '0) begin
      dec_d.wr_reg = 1'b0;
    end
    // Unused sources read x0
    dec_d.rs1 = dec_d.uses_rs1 ? rs1 : '0;
    dec_d.rs2 = dec_d.uses_rs2 ? rs2 : '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_o <= '0;
    end else if (!stall_i) begin
      dec_o <= dec_d;
    end
  end

endmodule

//--- fetch_unit.sv
module fetch_unit (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      stall_i,
  input  logic [core_pkg::XLEN-1:0] insn_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output core_pkg::fetch_pkt_t      fetch_o
);

  // PC and IF/ID register both freeze on stall
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o    <= core_pkg::RESET_PC;
      fetch_o <= '0;
    end else if (!stall_i) begin
      pc_o          <= pc_o + (core_pkg::XLEN)'(4);
      fetch_o.valid <= 1'b1;
      fetch_o.pc    <= pc_o;
      fetch_o.insn  <= insn_i;
    end
  end

endmodule

//--- core_pkg.sv
package core_pkg;

  localparam int XLEN        = 32;
  localparam int NUM_AREGS   = 32;
  localparam int REG_SEL     = 5;
  localparam int ROB_ENTRIES = 8;
  localparam int ROB_SEL     = 3;
  localparam int MUL_LATENCY = 3;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // IF to ID
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;
  } fetch_pkt_t;

  // ID to DP
  typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    pc;
    logic [REG_SEL-1:0] rd;
    logic [REG_SEL-1:0] rs1;
    logic [REG_SEL-1:0] rs2;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               wr_reg;
    logic               src_b_imm;
    logic [XLEN-1:0]    imm;
    isa_pkg::alu_op_e   alu_op;
    logic               is_mul;
    logic               illegal;
  } dec_pkt_t;

  typedef struct packed {
    logic               valid;
    logic               is_mul;
    isa_pkg::alu_op_e   alu_op;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [ROB_SEL-1:0] tag;
  } issue_pkt_t;

  typedef struct packed {
    logic               valid;
    logic [ROB_SEL-1:0] tag;
    logic [XLEN-1:0]    data;
  } wb_pkt_t;

  // New ROB entry
  typedef struct packed {
    logic               valid;
    logic [ROB_SEL-1:0] tag;
    logic [XLEN-1:0]    pc;
    logic [REG_SEL-1:0] rd;
    logic               wr_reg;
    logic               illegal;
  } dispatch_pkt_t;

  typedef struct packed {
    logic               valid;
    logic [ROB_SEL-1:0] tag;
    logic [XLEN-1:0]    pc;
    logic [REG_SEL-1:0] rd;
    logic               wr_reg;
    logic               illegal;
  } commit_pkt_t;

  typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    pc;
    logic [REG_SEL-1:0] rd;
    logic               wr_reg;
    logic [XLEN-1:0]    data;
    logic               illegal;
  } retire_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 codes
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // Operation requested of execute
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_MUL = 3'd6
  } alu_op_e;

endpackage
